// File: Bender.yml
package:
  name: xaui_pipe

export_include_dirs:
  - common

sources:
  - files:
      - common/xaui_pkg.sv
      - xaui_pipe/xaui_tx_gen.sv
      - xaui_pipe/xaui_rx_check.sv
      - logic/pipe_regs.sv
      - xaui_pipe/xaui_pipe.sv
  - target: test
    files:
      - bench/tb_xaui_pipe.sv

// File: bench/tb_xaui_pipe.sv
`timescale 1ns/1ps
`include "xaui_defines.svh"

module tb_xaui_pipe;

  import xaui_pkg::*;

  localparam logic [63:0] IDLE_COL = {8{`XAUI_COMMA}};

  logic        mgt_clk;
  logic        arst_n_i;
  logic [63:0] mgt_txdata;
  logic [7:0]  mgt_txcharisk;
  logic [63:0] mgt_rxdata;
  logic [7:0]  mgt_rxcharisk;
  logic [3:0]  mgt_syncok;
  logic        reg_valid;
  logic        reg_ready;
  logic        reg_we;
  reg_addr_e   reg_addr;
  logic [15:0] reg_wdata;
  logic [15:0] reg_rdata;
  logic        reg_rvalid;
  logic        led_link;

  byte         op_q[$];
  logic [15:0] addr_q[$];
  logic [15:0] data_q[$];
  logic [15:0] exp_q[$];
  int          seed;
  int          n_pass;
  int          n_fail;
  int          step_errs;
  int          tx_words;     // data words seen on the tx port
  bit          corrupt_req;
  int          corrupt_byte;
  logic [63:0] loop_data;    // first loopback stage
  logic [7:0]  loop_isk;
  bit          loaded;

  xaui_pipe UUT (
    .mgt_clk         (mgt_clk),
    .arst_n_i        (arst_n_i),
    .mgt_txdata_o    (mgt_txdata),
    .mgt_txcharisk_o (mgt_txcharisk),
    .mgt_rxdata_i    (mgt_rxdata),
    .mgt_rxcharisk_i (mgt_rxcharisk),
    .mgt_syncok_i    (mgt_syncok),
    .reg_valid_i     (reg_valid),
    .reg_ready_o     (reg_ready),
    .reg_we_i        (reg_we),
    .reg_addr_i      (reg_addr),
    .reg_wdata_i     (reg_wdata),
    .reg_rdata_o     (reg_rdata),
    .reg_rvalid_o    (reg_rvalid),
    .led_link_o      (led_link)
  );

  always #20 mgt_clk = ~mgt_clk;

  always @(posedge mgt_clk) begin
    if (mgt_txcharisk == 8'h00) begin
      tx_words = tx_words + 1;
    end
  end

  // tx looped to rx through two stages, optionally corrupting an idle byte
  always @(posedge mgt_clk) begin
    logic [63:0] tx_d;
    logic [7:0]  tx_k;
    tx_d = mgt_txdata;
    tx_k = mgt_txcharisk;
    #2;
    mgt_rxdata    = loop_data;
    mgt_rxcharisk = loop_isk;
    if (corrupt_req && tx_k == 8'hFF) begin
      tx_d[8*corrupt_byte +: 8] = ~tx_d[8*corrupt_byte +: 8];
      corrupt_req = 1'b0;
    end
    loop_data = tx_d;
    loop_isk  = tx_k;
  end

  task automatic log_mismatch(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    step_errs = step_errs + 1;
  endtask

  task automatic bus_request(input logic we, input logic [2:0] addr, input logic [15:0] data);
    @(posedge mgt_clk);
    #2;
    reg_valid = 1'b1;
    reg_we    = we;
    reg_addr  = reg_addr_e'(addr);
    reg_wdata = data;
    @(posedge mgt_clk);
    while (!reg_ready) begin
      @(posedge mgt_clk);
    end
    #2;
    reg_valid = 1'b0;
    reg_we    = 1'b0;
  endtask

  task automatic bus_read(input logic [2:0] addr, output logic [15:0] data, output bit ok);
    bus_request(1'b0, addr, 16'h0000);
    @(posedge mgt_clk);  // response cycle
    ok   = reg_rvalid;
    data = reg_rdata;
    if (reg_ready) begin
      log_mismatch("ready high during the read response");
    end
  endtask

  task automatic check_stream(input int n_words);
    int          seen;
    int          run;
    bit          have_prev;
    logic [63:0] prev;
    seen      = 0;
    run       = 0;
    have_prev = 1'b0;
    prev      = '0;
    @(posedge mgt_clk);
    while (mgt_txcharisk != 8'hFF) begin
      @(posedge mgt_clk);
    end
    while (seen < n_words) begin
      @(posedge mgt_clk);
      if (mgt_txcharisk == 8'hFF) begin
        if (run != 0 && run != `XAUI_IDLE_GAP) begin
          log_mismatch($sformatf("idle column after %0d data words", run));
        end
        if (mgt_txdata != IDLE_COL) begin
          log_mismatch($sformatf("idle column holds %h", mgt_txdata));
        end
        run = 0;
      end else if (mgt_txcharisk == 8'h00) begin
        if (have_prev && mgt_txdata != prev + 64'd1) begin
          log_mismatch($sformatf("data word %h after %h", mgt_txdata, prev));
        end
        if (run == `XAUI_IDLE_GAP) begin
          log_mismatch("idle column missing");
        end
        prev      = mgt_txdata;
        have_prev = 1'b1;
        run       = run + 1;
        seen      = seen + 1;
      end else begin
        log_mismatch($sformatf("mixed charisk %h", mgt_txcharisk));
      end
    end
  endtask

  task automatic load_steps(output bit ok);
    int    fd;
    int    n;
    int    a;
    int    d;
    int    e;
    string line;
    string op_s;
    ok = 1'b0;
    fd = $fopen("bench/xaui_testdata.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%s %h %h %h", op_s, a, d, e);
          if (n == 4) begin
            op_q.push_back(op_s[0]);
            addr_q.push_back(a[15:0]);
            data_q.push_back(d[15:0]);
            exp_q.push_back(e[15:0]);
          end
        end
      end
      $fclose(fd);
      ok = (op_q.size() > 0);
    end
  endtask

  initial begin
    bit          ok;
    bit          ok_hi;
    logic [15:0] rd;
    logic [15:0] rd_hi;
    int          tries;
    mgt_clk       = 1'b0;
    arst_n_i      = 1'b0;
    mgt_rxdata    = IDLE_COL;
    mgt_rxcharisk = 8'hFF;
    mgt_syncok    = 4'hF;
    reg_valid     = 1'b0;
    reg_we        = 1'b0;
    reg_addr      = REG_CTRL;
    reg_wdata     = 16'h0000;
    loop_data     = IDLE_COL;
    loop_isk      = 8'hFF;
    corrupt_req   = 1'b0;
    corrupt_byte  = 0;
    tx_words      = 0;
    n_pass        = 0;
    n_fail        = 0;
    seed          = 97;
    load_steps(ok);
    loaded = 1'b1;
    repeat (16) @(posedge mgt_clk);
    #2;
    arst_n_i = 1'b1;
    if (!ok) begin
      $display("test data file missing or empty");
      n_fail = n_fail + 1;
    end
    for (int i = 0; i < op_q.size(); i++) begin
      step_errs = 0;
      case (op_q[i])
        "W": bus_request(1'b1, addr_q[i][2:0], data_q[i]);
        "R": begin
          bus_read(addr_q[i][2:0], rd, ok);
          if (!ok) begin
            log_mismatch("no read response");
          end else if (rd !== exp_q[i]) begin
            log_mismatch($sformatf("addr %0d read %h, expected %h", addr_q[i], rd, exp_q[i]));
          end
        end
        "P": begin
          tries = 0;
          ok    = 1'b0;
          while (!(ok && rd === exp_q[i]) && tries < data_q[i]) begin
            bus_read(addr_q[i][2:0], rd, ok);
            tries = tries + 1;
          end
          if (!(ok && rd === exp_q[i])) begin
            log_mismatch($sformatf("addr %0d never read %h", addr_q[i], exp_q[i]));
          end else if (addr_q[i][2:0] == 3'(REG_STATUS) && led_link !== exp_q[i][0]) begin
            log_mismatch($sformatf("led_link is %b, lock bit %b", led_link, exp_q[i][0]));
          end
        end
        "D": repeat (data_q[i] + ($random(seed) & 7)) @(posedge mgt_clk);
        "X": begin
          @(negedge mgt_clk);
          corrupt_byte = addr_q[i];
          corrupt_req  = 1'b1;
        end
        "I": begin
          @(negedge mgt_clk);
          if (mgt_txcharisk !== 8'hFF || mgt_txdata !== IDLE_COL) begin
            log_mismatch($sformatf("tx not idle, %h / %h", mgt_txdata, mgt_txcharisk));
          end
          if (led_link !== exp_q[i][0]) begin
            log_mismatch($sformatf("led_link is %b", led_link));
          end
        end
        "S": check_stream(data_q[i]);
        "M": begin
          @(negedge mgt_clk);
          tx_words = 0;
        end
        "N": begin
          bus_read(3'(REG_WORDS_LO), rd, ok);
          bus_read(3'(REG_WORDS_HI), rd_hi, ok_hi);
          if (!ok || !ok_hi) begin
            log_mismatch("no read response");
          end else if ({rd_hi, rd} !== 32'(tx_words)) begin
            log_mismatch($sformatf("word count %0d, tx sent %0d", {rd_hi, rd}, tx_words));
          end
        end
        default: log_mismatch($sformatf("unknown operation %c", op_q[i]));
      endcase
      if (step_errs == 0) begin
        n_pass = n_pass + 1;
        $display("step %0d (%c) ok", i, op_q[i]);
      end else begin
        n_fail = n_fail + 1;
        $display("step %0d (%c) failed", i, op_q[i]);
      end
    end
    $display("steps passed %0d, steps failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    repeat (op_q.size() * 2000 + 16) @(posedge mgt_clk);
    $display("watchdog expired, the run did not finish in time");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: bench/xaui_testdata.txt
# op addr data expected, all hex; W write, R read, P poll (data = max reads)
# D wait cycles, X corrupt idle byte addr, I tx idle check, S stream check, M/N word count
I 0 0000 0000
R 0 0000 0000
R 1 0000 0000
R 2 0000 0000
R 3 0000 0000
R 4 0000 0000
R 7 0000 0000
W 0 0001 0000
R 0 0000 0001
S 0 0040 0000
P 1 0040 0001
R 2 0000 0000
W 0 0000 0000
D 0 0030 0000
W 0 0002 0000
M 0 0000 0000
W 0 0001 0000
D 0 0060 0000
W 0 0000 0000
D 0 0030 0000
N 0 0000 0000
R 2 0000 0000
W 0 0001 0000
P 1 0040 0001
W 0 0005 0000
D 0 0030 0000
R 2 0000 0001
P 1 0040 0001
X 5 0000 0000
D 0 0030 0000
R 2 0000 0002
W 0 0000 0000
D 0 0030 0000
W 0 0002 0000
D 0 0004 0000
R 2 0000 0000
R 3 0000 0000
R 4 0000 0000

// File: common/xaui_defines.svh
`ifndef XAUI_DEFINES_SVH
`define XAUI_DEFINES_SVH

// data words sent between two idle columns
`define XAUI_IDLE_GAP 15

// K28.5
`define XAUI_COMMA 8'hBC

// consecutive good data words before the checker reports lock
`define XAUI_LOCK_COUNT 4

// status counter widths
`define XAUI_ERR_W 16
`define XAUI_WORDS_W 32

// REG_CTRL bit positions
`define XAUI_CTRL_TX_EN 0
`define XAUI_CTRL_CLR 1
`define XAUI_CTRL_INJECT 2

`endif

// File: common/xaui_pkg.sv
package xaui_pkg;

  // one transceiver column, byte k belongs to lane k/2
  typedef union packed {
    logic [63:0]      seq;   // flat counting value
    logic [3:0][15:0] lane;  // lane 0 lowest
  } mgt_word_u;

  // host register map
  typedef enum logic [2:0] {
    REG_CTRL     = 3'd0,
    REG_STATUS   = 3'd1,
    REG_ERRS     = 3'd2,
    REG_WORDS_LO = 3'd3,
    REG_WORDS_HI = 3'd4
  } reg_addr_e;

endpackage

// File: logic/pipe_regs.sv
`timescale 1ns/1ps
`include "xaui_defines.svh"

module pipe_regs (
  input  logic                     mgt_clk,
  input  logic                     arst_n_i,
  input  logic                     reg_valid_i,
  output logic                     reg_ready_o,
  input  logic                     reg_we_i,
  input  xaui_pkg::reg_addr_e      reg_addr_i,
  input  logic [15:0]              reg_wdata_i,
  output logic [15:0]              reg_rdata_o,
  output logic                     reg_rvalid_o,
  input  logic                     locked_i,
  input  logic [`XAUI_ERR_W-1:0]   err_cnt_i,
  input  logic [`XAUI_WORDS_W-1:0] word_cnt_i,
  output logic                     tx_en_o,
  output logic                     inject_err_o,
  output logic                     clr_cnt_o
);

  import xaui_pkg::*;

  logic        req_ok;
  logic        rd_ok;
  logic        wr_ctrl;
  logic [15:0] rd_word;

  // one dead cycle while the read answer is out
  assign reg_ready_o = !reg_rvalid_o;

  assign req_ok  = reg_valid_i && reg_ready_o;
  assign rd_ok   = req_ok && !reg_we_i;
  assign wr_ctrl = req_ok && reg_we_i && (reg_addr_i == REG_CTRL);

  always_comb begin
    rd_word = 16'h0000;
    case (reg_addr_i)
      REG_CTRL: begin
        rd_word[`XAUI_CTRL_TX_EN] = tx_en_o;
      end
      REG_STATUS: begin
        rd_word[0] = locked_i;
      end
      REG_ERRS: begin
        rd_word = 16'(err_cnt_i);
      end
      REG_WORDS_LO: begin
        rd_word = word_cnt_i[0 +: 16];
      end
      REG_WORDS_HI: begin
        rd_word = word_cnt_i[16 +: 16];
      end
      default: begin
        rd_word = 16'h0000;  // unmapped
      end
    endcase
  end

  always_ff @(posedge mgt_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_en_o      <= 1'b0;
      inject_err_o <= 1'b0;
      clr_cnt_o    <= 1'b0;
      reg_rvalid_o <= 1'b0;
    end else begin
      reg_rvalid_o <= rd_ok;
      // clear and inject are self-clearing strobes
      clr_cnt_o    <= wr_ctrl && reg_wdata_i[`XAUI_CTRL_CLR];
      inject_err_o <= wr_ctrl && reg_wdata_i[`XAUI_CTRL_INJECT];
      if (wr_ctrl) begin
        tx_en_o <= reg_wdata_i[`XAUI_CTRL_TX_EN];
      end
    end
  end

  always_ff @(posedge mgt_clk) begin
    if (rd_ok) begin
      reg_rdata_o <= rd_word;
    end
  end

  // a read response lasts one cycle
  a_rvalid_pulse: assert property (@(posedge mgt_clk) disable iff (!arst_n_i)
    reg_rvalid_o |=> !reg_rvalid_o);

endmodule

// File: sim.f
+incdir+common
common/xaui_pkg.sv
xaui_pipe/xaui_tx_gen.sv
xaui_pipe/xaui_rx_check.sv
logic/pipe_regs.sv
xaui_pipe/xaui_pipe.sv
bench/tb_xaui_pipe.sv

// File: xaui_pipe/xaui_pipe.sv
`timescale 1ns/1ps
`include "xaui_defines.svh"

module xaui_pipe (
  input  logic                mgt_clk,
  input  logic                arst_n_i,
  // transceiver side
  output logic [63:0]         mgt_txdata_o,
  output logic [7:0]          mgt_txcharisk_o,
  input  logic [63:0]         mgt_rxdata_i,
  input  logic [7:0]          mgt_rxcharisk_i,
  input  logic [3:0]          mgt_syncok_i,
  // host register bus
  input  logic                reg_valid_i,
  output logic                reg_ready_o,
  input  logic                reg_we_i,
  input  xaui_pkg::reg_addr_e reg_addr_i,
  input  logic [15:0]         reg_wdata_i,
  output logic [15:0]         reg_rdata_o,
  output logic                reg_rvalid_o,
  output logic                led_link_o
);

  logic                     tx_en;
  logic                     inject_err;
  logic                     clr_cnt;
  logic                     locked;
  logic [`XAUI_ERR_W-1:0]   err_cnt;
  logic [`XAUI_WORDS_W-1:0] word_cnt;

  assign led_link_o = locked;

  xaui_tx_gen tx_gen_inst (
    .mgt_clk         (mgt_clk),
    .arst_n_i        (arst_n_i),
    .tx_en_i         (tx_en),
    .inject_err_i    (inject_err),
    .mgt_txdata_o    (mgt_txdata_o),
    .mgt_txcharisk_o (mgt_txcharisk_o)
  );

  xaui_rx_check rx_check_inst (
    .mgt_clk         (mgt_clk),
    .arst_n_i        (arst_n_i),
    .mgt_rxdata_i    (mgt_rxdata_i),
    .mgt_rxcharisk_i (mgt_rxcharisk_i),
    .mgt_syncok_i    (mgt_syncok_i),
    .clr_cnt_i       (clr_cnt),
    .locked_o        (locked),
    .err_cnt_o       (err_cnt),
    .word_cnt_o      (word_cnt)
  );

  pipe_regs regs_inst (
    .mgt_clk      (mgt_clk),
    .arst_n_i     (arst_n_i),
    .reg_valid_i  (reg_valid_i),
    .reg_ready_o  (reg_ready_o),
    .reg_we_i     (reg_we_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_rdata_o  (reg_rdata_o),
    .reg_rvalid_o (reg_rvalid_o),
    .locked_i     (locked),
    .err_cnt_i    (err_cnt),
    .word_cnt_i   (word_cnt),
    .tx_en_o      (tx_en),
    .inject_err_o (inject_err),
    .clr_cnt_o    (clr_cnt)
  );

endmodule

// File: xaui_pipe/xaui_rx_check.sv
`timescale 1ns/1ps
`include "xaui_defines.svh"

module xaui_rx_check (
  input  logic                     mgt_clk,
  input  logic                     arst_n_i,
  input  xaui_pkg::mgt_word_u      mgt_rxdata_i,
  input  logic [7:0]               mgt_rxcharisk_i,
  input  logic [3:0]               mgt_syncok_i,
  input  logic                     clr_cnt_i,
  output logic                     locked_o,
  output logic [`XAUI_ERR_W-1:0]   err_cnt_o,
  output logic [`XAUI_WORDS_W-1:0] word_cnt_o
);

  import xaui_pkg::*;

  localparam int RUN_W = $clog2(`XAUI_LOCK_COUNT + 1);
  localparam logic [RUN_W-1:0] RUN_MAX = RUN_W'(`XAUI_LOCK_COUNT);

  mgt_word_u        rx_q;
  logic [7:0]       isk_q;
  logic             sync_q;
  logic [63:0]      exp_q;
  logic             exp_vld_q;  // low until a data word seeds the sequence
  logic [RUN_W-1:0] run_q;      // good words in a row
  logic             is_data;
  logic             lane_bad;
  logic             seq_bad;
  logic             add_err;

  // input register, first of the two cycles
  always_ff @(posedge mgt_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      isk_q  <= 8'hFF;
      sync_q <= 1'b0;
    end else begin
      isk_q  <= mgt_rxcharisk_i;
      sync_q <= &mgt_syncok_i;
    end
  end

  always_ff @(posedge mgt_clk) begin
    rx_q <= mgt_rxdata_i;
  end

  // every lane of an idle column must be two commas
  always_comb begin
    lane_bad = 1'b0;
    for (int l = 0; l < 4; l++) begin
      if (rx_q.lane[l] != {2{`XAUI_COMMA}} || isk_q[2*l +: 2] != 2'b11) begin
        lane_bad = 1'b1;
      end
    end
  end

  assign is_data = (isk_q == 8'h00);
  assign seq_bad = exp_vld_q && (rx_q.seq != exp_q);
  assign add_err = sync_q && (is_data ? seq_bad : lane_bad);  // one per column

  always_ff @(posedge mgt_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exp_q     <= '0;
      exp_vld_q <= 1'b0;
      run_q     <= '0;
      locked_o  <= 1'b0;
    end else if (!sync_q) begin
      exp_vld_q <= 1'b0;
      run_q     <= '0;
      locked_o  <= 1'b0;
    end else if (add_err) begin
      run_q    <= '0;
      locked_o <= 1'b0;
      if (is_data) begin
        exp_vld_q <= 1'b0;  // reseed from the next data word
      end
    end else if (is_data) begin
      exp_q     <= rx_q.seq + 64'd1;
      exp_vld_q <= 1'b1;
      if (exp_vld_q) begin
        if (run_q != RUN_MAX) begin
          run_q <= run_q + 1'b1;
        end
        if (run_q >= RUN_MAX - 1'b1) begin
          locked_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge mgt_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_cnt_o  <= '0;
      word_cnt_o <= '0;
    end else if (clr_cnt_i) begin
      err_cnt_o  <= '0;
      word_cnt_o <= '0;
    end else begin
      if (add_err && err_cnt_o != '1) begin
        err_cnt_o <= err_cnt_o + 1'b1;  // saturating
      end
      if (is_data) begin
        word_cnt_o <= word_cnt_o + 1'b1;
      end
    end
  end

  // errors only pile up until the host clears them
  a_err_mono: assert property (@(posedge mgt_clk) disable iff (!arst_n_i)
    !$past(clr_cnt_i) |-> err_cnt_o >= $past(err_cnt_o));

endmodule

// File: xaui_pipe/xaui_tx_gen.sv
`timescale 1ns/1ps
`include "xaui_defines.svh"

module xaui_tx_gen (
  input  logic                mgt_clk,
  input  logic                arst_n_i,
  input  logic                tx_en_i,
  input  logic                inject_err_i,
  output xaui_pkg::mgt_word_u mgt_txdata_o,
  output logic [7:0]          mgt_txcharisk_o
);

  import xaui_pkg::*;

  localparam int GAP_W = $clog2(`XAUI_IDLE_GAP + 1);
  localparam logic [63:0] IDLE_COL = {8{`XAUI_COMMA}};

  logic             run_q;     // tx_en as seen at the last idle column
  logic [GAP_W-1:0] gap_q;     // data words sent since the last idle
  logic [63:0]      seq_q;
  logic             inject_q;
  logic             send_data;
  mgt_word_u        data_word;

  assign send_data = run_q && (gap_q != GAP_W'(`XAUI_IDLE_GAP));

  always_comb begin
    data_word.seq    = seq_q;
    data_word.seq[0] = seq_q[0] ^ inject_q;  // single bit error
  end

  always_ff @(posedge mgt_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      run_q            <= 1'b0;
      gap_q            <= '0;
      seq_q            <= '0;
      inject_q         <= 1'b0;
      mgt_txdata_o.seq <= IDLE_COL;
      mgt_txcharisk_o  <= 8'hFF;
    end else begin
      if (send_data) begin
        mgt_txdata_o    <= data_word;
        mgt_txcharisk_o <= 8'h00;
        seq_q           <= seq_q + 64'd1;  // count runs on past an injected word
        gap_q           <= gap_q + 1'b1;
        inject_q        <= inject_err_i;
      end else begin
        // tx_en is only picked up on an idle column
        mgt_txdata_o.seq <= IDLE_COL;
        mgt_txcharisk_o  <= 8'hFF;
        gap_q            <= '0;
        run_q            <= tx_en_i;
        inject_q         <= inject_q | inject_err_i;
      end
    end
  end

  // an idle column always follows a full gap of data words
  a_gap_idle: assert property (@(posedge mgt_clk) disable iff (!arst_n_i)
    gap_q == GAP_W'(`XAUI_IDLE_GAP) |=> mgt_txcharisk_o == 8'hFF);

endmodule
